// ==== compile.f ====
+incdir+design
design/os_gen_pkg.sv
design/os_field_builder.sv
design/os_symbol_sequencer.sv
design/os_lane_packer.sv
design/os_generator.sv
verif/os_generator_props.sv
verif/os_generator_checker.sv
verif/os_generator_tb.sv

// ==== Makefile ====
# Verilator build and run for the ordered-set generator

VERILATOR ?= verilator
TOP       ?= os_generator_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard design/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/os_generator_tb.sv ====
`timescale 1ns/1ps
`include "os_gen_macros.svh"

module os_generator_tb;

   import os_gen_pkg::*;

   localparam int NUM_LANES  = 4;
   localparam int PIPE_WIDTH = 16;
   localparam int SYMS       = PIPE_WIDTH / `OS_SYM_W;
   localparam int WAIT_LIMIT = 100;
   localparam logic [7:0] TS_BEATS = 8'(`OS_BLOCK_SYMS / SYMS);
   localparam logic [7:0] SH_BEATS = 8'(`OS_SHORT_SYMS / SYMS);

   typedef struct packed {
      os_type_e    kind;
      lane_mode_e  mode;
      logic [7:0]  link;
      logic [2:0]  rate;
      logic        lb;
      logic [7:0]  beats;   // expected beats of the set
   } req_t;

   logic                              pclk = 1'b0;
   logic                              reset_n;
   logic                              start;
   os_type_e                          os_type;
   lane_mode_e                        lane_mode;
   logic [7:0]                        link_number;
   logic [2:0]                        rate;
   logic                              loopback;
   logic [7:0]                        exp_beats;
   logic                              busy;
   logic                              finish;
   logic [NUM_LANES*PIPE_WIDTH-1:0]   pipe_data;
   logic [NUM_LANES*SYMS-1:0]         pipe_datak;
   logic [NUM_LANES*SYMS-1:0]         pipe_datavalid;
   int                                errors;
   int                                sets_done;
   int                                timeouts = 0;
   req_t                              table_q [$];

   // link zero, every lane mode, short sets
   req_t directed [10] = '{
      '{TS1,  SEQ, 8'h01, 3'd1, 1'b0, TS_BEATS},
      '{TS2,  SEQ, 8'h05, 3'd2, 1'b1, TS_BEATS},
      '{TS1,  SEQ, 8'h00, 3'd3, 1'b0, TS_BEATS},
      '{TS2,  REV, 8'h00, 3'd4, 1'b1, TS_BEATS},
      '{TS1,  PAD, 8'h12, 3'd5, 1'b0, TS_BEATS},
      '{TS2,  REV, 8'h7F, 3'd6, 1'b0, TS_BEATS},
      '{TS1,  lane_mode_e'(2'd3), 8'hC3, 3'd7, 1'b1, TS_BEATS},
      '{SKP,  PAD, 8'h00, 3'd0, 1'b0, SH_BEATS},
      '{EIOS, SEQ, 8'h33, 3'd2, 1'b1, SH_BEATS},
      '{SKP,  REV, 8'h44, 3'd1, 1'b0, SH_BEATS}
   };

   always #4 pclk = ~pclk;

   os_generator #(
      .NUM_LANES  (NUM_LANES),
      .PIPE_WIDTH (PIPE_WIDTH)
   ) os_generator_i (
      .pclk (pclk), .reset_n (reset_n), .start (start), .os_type (os_type),
      .lane_mode (lane_mode), .link_number (link_number), .rate (rate),
      .loopback (loopback), .busy (busy), .finish (finish), .pipe_data (pipe_data),
      .pipe_datak (pipe_datak), .pipe_datavalid (pipe_datavalid)
   );

   os_generator_checker #(
      .NUM_LANES  (NUM_LANES),
      .PIPE_WIDTH (PIPE_WIDTH)
   ) checker_i (
      .pclk (pclk), .reset_n (reset_n), .start (start), .os_type (os_type),
      .lane_mode (lane_mode), .link_number (link_number), .rate (rate),
      .loopback (loopback), .exp_beats (exp_beats), .busy (busy), .finish (finish),
      .pipe_data (pipe_data), .pipe_datak (pipe_datak), .pipe_datavalid (pipe_datavalid),
      .errors (errors), .sets_done (sets_done)
   );

   bind os_generator os_generator_props #(
      .NUM_LANES  (NUM_LANES),
      .PIPE_WIDTH (PIPE_WIDTH)
   ) u_props (
      .pclk (pclk), .reset_n (reset_n), .busy (busy), .finish (finish),
      .pipe_data (pipe_data), .pipe_datak (pipe_datak), .pipe_datavalid (pipe_datavalid)
   );

   task automatic send_request(input req_t r);
      @(negedge pclk);
      start       = 1'b1;   // one-cycle strobe
      os_type     = r.kind;
      lane_mode   = r.mode;
      link_number = r.link;
      rate        = r.rate;
      loopback    = r.lb;
      exp_beats   = r.beats;
      @(negedge pclk);
      start = 1'b0;
   endtask

   task automatic wait_finish();
      int n;
      n = 0;
      while (finish !== 1'b1 && n < WAIT_LIMIT) begin
         @(negedge pclk);
         n++;
      end
      if (finish !== 1'b1) begin
         timeouts++;
         $display("timeout at %0t, finish not seen within %0d cycles", $time, WAIT_LIMIT);
      end
   endtask

   task automatic wait_busy();
      int n;
      n = 0;
      while (busy !== 1'b1 && n < WAIT_LIMIT) begin
         @(negedge pclk);
         n++;
      end
      if (busy !== 1'b1) begin
         timeouts++;
         $display("timeout at %0t, busy never rose", $time);
      end
   endtask

   initial begin
      req_t r;
      void'($urandom(89));
      reset_n     = 1'b0;
      start       = 1'b0;
      os_type     = TS1;
      lane_mode   = PAD;
      link_number = 8'h00;
      rate        = 3'd0;
      loopback    = 1'b0;
      exp_beats   = 8'd0;
      repeat (5) @(negedge pclk);
      reset_n = 1'b1;
      repeat (2) @(negedge pclk);

      foreach (directed[i])
         table_q.push_back(directed[i]);
      for (int t = 0; t < 2; t++) begin          // every rate and loopback on TS1 and TS2
         for (int rt = 0; rt < 8; rt++) begin
            for (int lb = 0; lb < 2; lb++) begin
               r = '{os_type_e'(t), SEQ, 8'h2A, 3'(rt), 1'(lb), TS_BEATS};
               table_q.push_back(r);
            end
         end
      end
      repeat (6) begin
         r.kind  = ($urandom % 2 == 0) ? TS1 : TS2;
         r.mode  = lane_mode_e'(2'($urandom));
         r.link  = 8'($urandom);
         r.rate  = 3'($urandom);
         r.lb    = 1'($urandom);
         r.beats = TS_BEATS;
         table_q.push_back(r);
      end

      foreach (table_q[i]) begin
         send_request(table_q[i]);
         wait_finish();
         repeat (2) @(negedge pclk);              // idle gap between sets
      end

      // second request while the first set is still on the bus
      send_request(directed[0]);
      wait_busy();
      @(negedge pclk);
      r = '{TS2, REV, 8'h09, 3'd2, 1'b1, TS_BEATS};
      send_request(r);
      wait_finish();
      repeat (2) @(negedge pclk);
      send_request(directed[1]);
      wait_busy();
      send_request(directed[8]);                  // EIOS cuts into a TS2
      wait_finish();
      repeat (4) @(negedge pclk);

      $display("sets completed %0d, errors %0d, timeouts %0d", sets_done, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== verif/os_generator_checker.sv ====
`timescale 1ns/1ps
`include "os_gen_macros.svh"

module os_generator_checker #(
   parameter int NUM_LANES  = `OS_NUM_LANES,
   parameter int PIPE_WIDTH = `OS_PIPE_WIDTH
) (
   input  logic                                         pclk,
   input  logic                                         reset_n,
   input  logic                                         start,
   input  os_gen_pkg::os_type_e                         os_type,
   input  os_gen_pkg::lane_mode_e                       lane_mode,
   input  logic [7:0]                                   link_number,
   input  logic [2:0]                                   rate,
   input  logic                                         loopback,
   input  logic [7:0]                                   exp_beats,
   input  logic                                         busy,
   input  logic                                         finish,
   input  logic [NUM_LANES*PIPE_WIDTH-1:0]              pipe_data,
   input  logic [NUM_LANES*(PIPE_WIDTH/`OS_SYM_W)-1:0]  pipe_datak,
   input  logic [NUM_LANES*(PIPE_WIDTH/`OS_SYM_W)-1:0]  pipe_datavalid,
   output int                                           errors,
   output int                                           sets_done
);

   import os_gen_pkg::*;

   localparam int SYMS = PIPE_WIDTH / `OS_SYM_W;

   os_type_e    cur_type, pend_type;     // set on the bus, set waiting for its first beat
   lane_mode_e  cur_mode, pend_mode;
   logic [7:0]  cur_link, pend_link;
   logic [2:0]  cur_rate, pend_rate;
   logic        cur_lb, pend_lb;
   logic [7:0]  cur_exp, pend_exp;
   logic        cur_valid = 1'b0;
   logic        pend_valid = 1'b0;
   int          cur_begin = 0;
   int          pend_begin = 0;
   int          cyc = 0;
   int          run_beats = 0;
   int          err_count = 0;
   int          done_count = 0;

   assign errors    = err_count;
   assign sets_done = done_count;

   // {k, symbol} of one lane at one symbol position
   function automatic logic [8:0] expect_sym(input int lane, input int idx);
      if (cur_type == SKP || cur_type == EIOS) begin
         if (idx == 0)
            return {1'b1, `OS_COM};
         return {1'b1, (cur_type == SKP) ? `OS_SKP : `OS_IDL};
      end
      case (idx)
         0: return {1'b1, `OS_COM};
         1: return (cur_link == 8'h00) ? {1'b1, `OS_PAD} : {1'b0, cur_link};
         2: begin
            if (cur_mode == PAD)
               return {1'b1, `OS_PAD};
            if (cur_mode == SEQ)
               return {1'b0, 8'(lane + 1)};
            return {1'b0, 8'(NUM_LANES - lane)};   // reversed, also for mode 3
         end
         3: return 9'h000;
         4: begin
            case (cur_rate)
               3'd1:    return 9'h002;
               3'd2:    return 9'h004;
               3'd3:    return 9'h008;
               3'd4:    return 9'h010;
               default: return 9'h020;
            endcase
         end
         5: return {1'b0, cur_lb ? 8'h04 : 8'h00};
         default: return {1'b0, (cur_type == TS2) ? `OS_TS2_ID : `OS_TS1_ID};
      endcase
   endfunction

   function automatic int set_beats();
      if (cur_type == SKP || cur_type == EIOS)
         return `OS_SHORT_SYMS / SYMS;
      return `OS_BLOCK_SYMS / SYMS;
   endfunction

   task automatic report_fail(input string what);
      err_count++;
      $display("Fail %0t: %s", $time, what);
   endtask

   task automatic compare_beat(input int beat, input int last);
      logic [8:0] e;
      logic [7:0] got;
      for (int l = 0; l < NUM_LANES; l++) begin
         for (int s = 0; s < SYMS; s++) begin
            e   = expect_sym(l, beat * SYMS + s);
            got = pipe_data[l*PIPE_WIDTH + s*`OS_SYM_W +: `OS_SYM_W];
            if (got !== e[7:0] || pipe_datak[l*SYMS + s] !== e[8])
               report_fail($sformatf("lane %0d symbol %0d is %h k%b, expected %h k%b",
                  l, beat * SYMS + s, got, pipe_datak[l*SYMS + s], e[7:0], e[8]));
         end
      end
      if (pipe_datavalid !== '1)
         report_fail($sformatf("datavalid %b on beat %0d", pipe_datavalid, beat));
      if (busy !== (beat != last) || finish !== (beat == last))
         report_fail($sformatf("busy %b finish %b on beat %0d of %0d",
            busy, finish, beat, last + 1));
   endtask

   task automatic compare_idle();
      if (pipe_data !== '0 || pipe_datak !== '0 || pipe_datavalid !== '0 ||
          busy !== 1'b0 || finish !== 1'b0)
         report_fail($sformatf("bus not idle, data %h k %b valid %b busy %b finish %b",
            pipe_data, pipe_datak, pipe_datavalid, busy, finish));
   endtask

   always @(posedge pclk) begin
      int beat;
      cyc++;
      if (!reset_n) begin
         cur_valid  = 1'b0;
         pend_valid = 1'b0;
      end else begin
         if (pend_valid && cyc == pend_begin) begin   // new set takes over, old one is dropped
            cur_type   = pend_type;
            cur_mode   = pend_mode;
            cur_link   = pend_link;
            cur_rate   = pend_rate;
            cur_lb     = pend_lb;
            cur_exp    = pend_exp;
            cur_begin  = cyc;
            cur_valid  = 1'b1;
            pend_valid = 1'b0;
            run_beats  = 0;
         end
         beat = cyc - cur_begin;
         if (cur_valid && beat < set_beats()) begin
            compare_beat(beat, set_beats() - 1);
            run_beats++;
            if (finish === 1'b1) begin
               done_count++;
               if (run_beats != int'(cur_exp))
                  report_fail($sformatf("set ended after %0d beats, expected %0d",
                     run_beats, cur_exp));
            end
         end else begin
            compare_idle();
         end
         if (start) begin
            pend_type  = os_type;
            pend_mode  = lane_mode;
            pend_link  = link_number;
            pend_rate  = rate;
            pend_lb    = loopback;
            pend_exp   = exp_beats;
            pend_begin = cyc + 2;   // first beat two edges after start
            pend_valid = 1'b1;
         end
      end
   end

endmodule

// ==== verif/os_generator_props.sv ====
`timescale 1ns/1ps
`include "os_gen_macros.svh"

module os_generator_props #(
   parameter int NUM_LANES  = `OS_NUM_LANES,
   parameter int PIPE_WIDTH = `OS_PIPE_WIDTH
) (
   input logic                                         pclk,
   input logic                                         reset_n,
   input logic                                         busy,
   input logic                                         finish,
   input logic [NUM_LANES*PIPE_WIDTH-1:0]              pipe_data,
   input logic [NUM_LANES*(PIPE_WIDTH/`OS_SYM_W)-1:0]  pipe_datak,
   input logic [NUM_LANES*(PIPE_WIDTH/`OS_SYM_W)-1:0]  pipe_datavalid
);

   // busy drops on the beat that carries finish
   busy_finish_excl : assert property (@(posedge pclk) disable iff (!reset_n)
      !(busy && finish)) else $error("busy and finish high together");

   finish_pulse : assert property (@(posedge pclk) disable iff (!reset_n)
      finish |=> !finish) else $error("finish held longer than one cycle");

   valid_uniform : assert property (@(posedge pclk) disable iff (!reset_n)
      (pipe_datavalid == '0) || (pipe_datavalid == '1))
      else $error("datavalid mixes set and clear bits");

   // sync reset, bus is clear one edge after reset is seen
   reset_clear : assert property (@(posedge pclk) !reset_n |=>
      (pipe_data == '0 && pipe_datak == '0 && pipe_datavalid == '0 && !busy && !finish))
      else $error("outputs not cleared while reset is held");

endmodule

// ==== design/os_generator.sv ====
`timescale 1ns/1ps
`include "os_gen_macros.svh"

module os_generator #(
   parameter int NUM_LANES  = `OS_NUM_LANES,
   parameter int PIPE_WIDTH = `OS_PIPE_WIDTH
) (
   input  logic                                         pclk,
   input  logic                                         reset_n,
   input  logic                                         start,
   input  os_gen_pkg::os_type_e                         os_type,
   input  os_gen_pkg::lane_mode_e                       lane_mode,
   input  logic [7:0]                                   link_number,
   input  logic [2:0]                                   rate,
   input  logic                                         loopback,
   output logic                                         busy,
   output logic                                         finish,
   output logic [NUM_LANES*PIPE_WIDTH-1:0]              pipe_data,
   output logic [NUM_LANES*(PIPE_WIDTH/`OS_SYM_W)-1:0]  pipe_datak,
   output logic [NUM_LANES*(PIPE_WIDTH/`OS_SYM_W)-1:0]  pipe_datavalid
);

   import os_gen_pkg::*;

   logic        load;
   os_block_u   block;
   os_type_e    block_type;
   lane_mode_e  block_lane_mode;
   logic        beat_valid;
   logic [3:0]  sym_index;
   logic        beat_last;

   // request capture and symbol assembly
   os_field_builder u_builder (
      .pclk            (pclk),
      .reset_n         (reset_n),
      .start           (start),
      .os_type         (os_type),
      .lane_mode       (lane_mode),
      .link_number     (link_number),
      .rate            (rate),
      .loopback        (loopback),
      .load            (load),
      .block           (block),
      .block_type      (block_type),
      .block_lane_mode (block_lane_mode)
   );

   os_symbol_sequencer #(
      .PIPE_WIDTH (PIPE_WIDTH)
   ) u_sequencer (
      .pclk       (pclk),
      .reset_n    (reset_n),
      .load       (load),
      .block_type (block_type),
      .beat_valid (beat_valid),
      .sym_index  (sym_index),
      .beat_last  (beat_last)
   );

   // output register stage onto the PIPE bus
   os_lane_packer #(
      .NUM_LANES  (NUM_LANES),
      .PIPE_WIDTH (PIPE_WIDTH)
   ) u_packer (
      .pclk            (pclk),
      .reset_n         (reset_n),
      .block           (block),
      .block_type      (block_type),
      .block_lane_mode (block_lane_mode),
      .beat_valid      (beat_valid),
      .sym_index       (sym_index),
      .beat_last       (beat_last),
      .pipe_data       (pipe_data),
      .pipe_datak      (pipe_datak),
      .pipe_datavalid  (pipe_datavalid),
      .busy            (busy),
      .finish          (finish)
   );

endmodule

// ==== design/os_lane_packer.sv ====
`timescale 1ns/1ps
`include "os_gen_macros.svh"

module os_lane_packer #(
   parameter int NUM_LANES  = `OS_NUM_LANES,
   parameter int PIPE_WIDTH = `OS_PIPE_WIDTH
) (
   input  logic                                         pclk,
   input  logic                                         reset_n,
   input  os_gen_pkg::os_block_u                        block,
   input  os_gen_pkg::os_type_e                         block_type,
   input  os_gen_pkg::lane_mode_e                       block_lane_mode,
   input  logic                                         beat_valid,
   input  logic [3:0]                                   sym_index,
   input  logic                                         beat_last,
   output logic [NUM_LANES*PIPE_WIDTH-1:0]              pipe_data,
   output logic [NUM_LANES*(PIPE_WIDTH/`OS_SYM_W)-1:0]  pipe_datak,
   output logic [NUM_LANES*(PIPE_WIDTH/`OS_SYM_W)-1:0]  pipe_datavalid,
   output logic                                         busy,
   output logic                                         finish
);

   import os_gen_pkg::*;

   localparam int SYMS = PIPE_WIDTH / `OS_SYM_W;

   os_sym_t                            lane_sym [NUM_LANES];
   logic                               lane_k;
   logic                               is_ts;
   logic [NUM_LANES*PIPE_WIDTH-1:0]    data_d;
   logic [NUM_LANES*SYMS-1:0]          k_d;

   assign is_ts  = (block_type == TS1) || (block_type == TS2);
   assign lane_k = (block_lane_mode == PAD);

   // lane number field of every lane
   always_comb begin
      for (int l = 0; l < NUM_LANES; l++) begin
         case (block_lane_mode)
            PAD:     lane_sym[l] = `OS_PAD;
            SEQ:     lane_sym[l] = 8'(l + 1);
            default: lane_sym[l] = 8'(NUM_LANES - l);   // reversed numbering
         endcase
      end
   end

   always_comb begin
      logic [3:0] idx;
      os_sym_t    sym;
      logic       k;

      data_d = '0;
      k_d    = '0;
      for (int l = 0; l < NUM_LANES; l++) begin
         for (int s = 0; s < SYMS; s++) begin
            idx = sym_index + 4'(s);   // earlier symbol in the lower byte
            sym = block.sym[idx];
            k   = 1'b0;
            if (!is_ts) begin
               k = 1'b1;               // SKP and EIOS are all K
            end else if (idx == 4'd0) begin
               k = 1'b1;               // COM
            end else if (idx == 4'd1) begin
               k = (sym == `OS_PAD);   // link PAD
            end else if (idx == 4'd2) begin
               sym = lane_sym[l];
               k   = lane_k;
            end
            data_d[l*PIPE_WIDTH + s*`OS_SYM_W +: `OS_SYM_W] = sym;
            k_d[l*SYMS + s] = k;
         end
      end
   end

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         pipe_data      <= '0;
         pipe_datak     <= '0;
         pipe_datavalid <= '0;
         busy           <= 1'b0;
         finish         <= 1'b0;
      end else if (beat_valid) begin
         pipe_data      <= data_d;
         pipe_datak     <= k_d;
         pipe_datavalid <= '1;
         busy           <= !beat_last;
         finish         <= beat_last;  // single pulse on the final beat
      end else begin
         pipe_data      <= '0;        // idle bus between sets
         pipe_datak     <= '0;
         pipe_datavalid <= '0;
         busy           <= 1'b0;
         finish         <= 1'b0;
      end
   end

endmodule

// ==== design/os_symbol_sequencer.sv ====
`timescale 1ns/1ps
`include "os_gen_macros.svh"

module os_symbol_sequencer #(
   parameter int PIPE_WIDTH = `OS_PIPE_WIDTH
) (
   input  logic                  pclk,
   input  logic                  reset_n,
   input  logic                  load,
   input  os_gen_pkg::os_type_e  block_type,
   output logic                  beat_valid,
   output logic [3:0]            sym_index,
   output logic                  beat_last
);

   import os_gen_pkg::*;

   localparam int SYMS = PIPE_WIDTH / `OS_SYM_W;  // symbols per lane per beat

   logic        sending;
   logic [3:0]  count;
   logic [4:0]  set_len;
   logic [4:0]  beat_end;

   // SKP and EIOS are short sets, block_type holds until the next load
   assign set_len = (block_type == SKP || block_type == EIOS) ?
                    5'(`OS_SHORT_SYMS) : 5'(`OS_BLOCK_SYMS);

   // the load cycle already carries the first beat
   assign beat_valid = load | sending;
   assign sym_index  = load ? 4'd0 : count;
   assign beat_end   = {1'b0, sym_index} + 5'(SYMS);
   assign beat_last  = beat_valid && (beat_end >= set_len);

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         sending <= 1'b0;
         count   <= 4'd0;
      end else if (load) begin
         // restart drops any unfinished set
         count   <= 4'(SYMS);
         sending <= !beat_last;
      end else if (sending) begin
         count   <= count + 4'(SYMS);
         sending <= !beat_last;
      end
   end

endmodule

// ==== design/os_field_builder.sv ====
`timescale 1ns/1ps
`include "os_gen_macros.svh"

module os_field_builder (
   input  logic                    pclk,
   input  logic                    reset_n,
   input  logic                    start,
   input  os_gen_pkg::os_type_e    os_type,
   input  os_gen_pkg::lane_mode_e  lane_mode,
   input  logic [7:0]              link_number,
   input  logic [2:0]              rate,
   input  logic                    loopback,
   output logic                    load,
   output os_gen_pkg::os_block_u   block,
   output os_gen_pkg::os_type_e    block_type,
   output os_gen_pkg::lane_mode_e  block_lane_mode
);

   import os_gen_pkg::*;

   os_block_u  next_block;
   os_sym_t    rate_id;
   os_sym_t    ident_sym;
   os_sym_t    short_fill;
   logic       link_pad;

   assign link_pad   = (link_number == 8'h00);  // no link assigned yet
   assign ident_sym  = (os_type == TS2) ? `OS_TS2_ID : `OS_TS1_ID;
   assign short_fill = (os_type == SKP) ? `OS_SKP : `OS_IDL;

   // data rate identifier, one-hot shifted by rate
   always_comb begin
      case (rate)
         3'd1:    rate_id = 8'h02;
         3'd2:    rate_id = 8'h04;
         3'd3:    rate_id = 8'h08;
         3'd4:    rate_id = 8'h10;
         default: rate_id = 8'h20;
      endcase
   end

   always_comb begin
      next_block = '0;
      if (os_type == SKP || os_type == EIOS) begin
         next_block.sym[0] = `OS_COM;
         for (int i = 1; i < `OS_SHORT_SYMS; i++) begin
            next_block.sym[i] = short_fill;
         end
      end else begin
         next_block.ts.com       = `OS_COM;
         next_block.ts.link      = link_pad ? `OS_PAD : link_number;
         next_block.ts.lane      = `OS_PAD;              // packer fills per lane
         next_block.ts.n_fts     = 8'h00;
         next_block.ts.rate_id   = rate_id;
         next_block.ts.train_ctl = {5'b0, loopback, 2'b0}; // loopback is bit 2
         next_block.ts.ident     = {10{ident_sym}};
      end
   end

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         load <= 1'b0;
      end else begin
         load <= start;
      end
   end

   // request payload, held until the next start
   always_ff @(posedge pclk) begin
      if (start) begin
         block           <= next_block;
         block_type      <= os_type;
         block_lane_mode <= lane_mode;
      end
   end

endmodule

// ==== design/os_gen_pkg.sv ====
`include "os_gen_macros.svh"

package os_gen_pkg;

   // encoding follows the LTSSM request
   typedef enum logic [1:0] {
      TS1  = 2'd0,
      TS2  = 2'd1,
      SKP  = 2'd2,
      EIOS = 2'd3
   } os_type_e;

   // lane number field handling, any value above SEQ is treated as reversed
   typedef enum logic [1:0] {
      PAD = 2'd0,
      SEQ = 2'd1,
      REV = 2'd2
   } lane_mode_e;

   typedef logic [`OS_SYM_W-1:0] os_sym_t;

   // listed from symbol 15 down so that com lands on the lowest byte
   typedef struct packed {
      os_sym_t [9:0] ident;      // symbols 6..15
      os_sym_t       train_ctl;  // symbol 5
      os_sym_t       rate_id;    // symbol 4
      os_sym_t       n_fts;      // symbol 3
      os_sym_t       lane;       // symbol 2
      os_sym_t       link;       // symbol 1
      os_sym_t       com;        // symbol 0
   } ts_fields_s;

   // same 128 bits seen as named fields or as symbol slots
   typedef union packed {
      ts_fields_s                        ts;
      os_sym_t [`OS_BLOCK_SYMS-1:0]      sym;
   } os_block_u;

endpackage

// ==== design/os_gen_macros.svh ====
`ifndef OS_GEN_MACROS_SVH
`define OS_GEN_MACROS_SVH

// symbol and lane geometry
`define OS_SYM_W       8      // one 8b/10b symbol before encoding
`define OS_PIPE_WIDTH  16     // bits per lane per pclk
`define OS_NUM_LANES   4
`define OS_BLOCK_SYMS  16     // TS1 / TS2 length
`define OS_SHORT_SYMS  4      // SKP / EIOS length

// K codes
`define OS_COM         8'hBC  // K28.5
`define OS_PAD         8'hF7  // K23.7
`define OS_SKP         8'h1C  // K28.0
`define OS_IDL         8'h7C  // K28.3

// training set identifiers, D codes
`define OS_TS1_ID      8'h4A  // D10.2
`define OS_TS2_ID      8'h45  // D5.2

`endif
